// File: tb.f
common/wb_pkg.sv
wbu/wbu.sv
src/gpr_file.sv
src/csr_file.sv
src/operand_read.sv
src/wb_subsys_top.sv
verif/wb_props.sv
verif/wb_checker.sv
verif/wb_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wall -f tb.f --top-module wb_tb -o Vwb_tb

run: build
	./obj_dir/Vwb_tb | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing --assert -Wall -f tb.f --top-module wb_tb

clean:
	rm -rf obj_dir $(LOG)

// File: verif/wb_tb.sv
// Writeback subsystem testbench top.
// Generates clock and reset, applies the stimulus table one entry per
// cycle with LFSR data words, and reports the overall result.

module wb_tb;

    localparam logic [wb_pkg::xlen-1:0] mtvec_reset  = 32'h0000_0100;
    localparam int                      settle_limit = 50;

    logic                             clk;
    logic                             rst_n;
    logic                             valid;
    logic [wb_pkg::xlen-1:0]          mem_rdata;
    logic [wb_pkg::xlen-1:0]          ex_result;
    logic [wb_pkg::xlen-1:0]          csrs;
    logic [wb_pkg::xlen-1:0]          pc;
    logic [wb_pkg::reg_idx_w-1:0]     rd;
    logic [wb_pkg::csr_count-1:0]     csr_wen;
    logic                             r_wen;
    logic                             mem_ren;
    logic                             jump_flag;
    logic [wb_pkg::reg_idx_w-1:0]     rs1_addr;
    logic [wb_pkg::csr_idx_w-1:0]     csr_ridx;
    logic [wb_pkg::xlen-1:0]          rs1_data;
    logic [wb_pkg::xlen-1:0]          csr_data;
    int                               error_count;
    int                               check_count;

    // Each entry packs valid, rd, r_wen, mem_ren, jump_flag, csr_wen, rs1_addr and csr_ridx.
    logic [19:0]                      steps[$];
    logic [15:0]                      lfsr;

    wb_subsys_top #(
        .mtvec_reset (mtvec_reset)
    ) wb_subsys_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid     (valid),
        .mem_rdata (mem_rdata),
        .ex_result (ex_result),
        .csrs      (csrs),
        .pc        (pc),
        .rd        (rd),
        .csr_wen   (csr_wen),
        .r_wen     (r_wen),
        .mem_ren   (mem_ren),
        .jump_flag (jump_flag),
        .rs1_addr  (rs1_addr),
        .csr_ridx  (csr_ridx),
        .rs1_data  (rs1_data),
        .csr_data  (csr_data)
    );

    wb_checker #(
        .mtvec_reset (mtvec_reset)
    ) wb_checker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid       (wb_subsys_top_i.valid),
        .mem_rdata   (wb_subsys_top_i.mem_rdata),
        .ex_result   (wb_subsys_top_i.ex_result),
        .csrs        (wb_subsys_top_i.csrs),
        .pc          (wb_subsys_top_i.pc),
        .rd          (wb_subsys_top_i.rd),
        .csr_wen     (wb_subsys_top_i.csr_wen),
        .r_wen       (wb_subsys_top_i.r_wen),
        .mem_ren     (wb_subsys_top_i.mem_ren),
        .jump_flag   (wb_subsys_top_i.jump_flag),
        .rs1_addr    (wb_subsys_top_i.rs1_addr),
        .csr_ridx    (wb_subsys_top_i.csr_ridx),
        .rs1_data    (wb_subsys_top_i.rs1_data),
        .csr_data    (wb_subsys_top_i.csr_data),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR with taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic next_word(output logic [wb_pkg::xlen-1:0] w);
        w = '0;
        for (int b = 0; b < wb_pkg::xlen; b++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[wb_pkg::xlen-2:0], lfsr[0]};
        end
    endtask

    task automatic add_step(input logic v, input logic [4:0] rd_i, input logic rw,
                            input logic mr, input logic jf, input logic [3:0] cw,
                            input logic [4:0] ra, input logic [1:0] ci);
        steps.push_back({v, rd_i, rw, mr, jf, cw, ra, ci});
    endtask

    task automatic build_table();
        // Reset state reads.
        add_step(0, 0, 0, 0, 0, 4'b0000, 0, 0);
        add_step(0, 0, 0, 0, 0, 4'b0000, 5, 1);
        add_step(0, 0, 0, 0, 0, 4'b0000, 31, 2);
        add_step(0, 0, 0, 0, 0, 4'b0000, 17, 3);
        // Each flag combination of the value priority is read back in the next cycle.
        add_step(1, 1, 1, 0, 0, 4'b0000, 0, 0);
        add_step(1, 2, 1, 1, 0, 4'b0000, 1, 0);
        add_step(1, 3, 1, 0, 1, 4'b0000, 2, 0);
        add_step(1, 4, 1, 1, 1, 4'b0000, 3, 0);
        add_step(1, 5, 1, 0, 0, 4'b0001, 4, 0);
        add_step(1, 6, 1, 1, 0, 4'b0010, 5, 1);
        add_step(1, 7, 1, 0, 1, 4'b0100, 6, 2);
        add_step(1, 8, 1, 1, 1, 4'b1000, 7, 3);
        // With valid low the committed values are read again and must hold.
        add_step(0, 0, 0, 0, 0, 4'b0000, 8, 3);
        add_step(0, 0, 0, 0, 0, 4'b0000, 1, 0);
        add_step(0, 0, 0, 0, 0, 4'b0000, 4, 1);
        add_step(0, 0, 0, 0, 0, 4'b0000, 7, 2);
        // Writes to x0.
        add_step(1, 0, 1, 0, 0, 4'b0000, 0, 0);
        add_step(1, 0, 1, 1, 0, 4'b0000, 0, 0);
        add_step(0, 0, 0, 0, 0, 4'b0000, 0, 0);
        // No register write enable.
        add_step(1, 9, 0, 0, 0, 4'b0000, 9, 0);
        add_step(0, 0, 0, 0, 0, 4'b0000, 9, 0);
        // CSR writes with single bits and combinations.
        add_step(1, 0, 0, 0, 0, 4'b0001, 0, 0);
        add_step(1, 0, 0, 0, 0, 4'b0010, 0, 0);
        add_step(1, 0, 0, 0, 0, 4'b0100, 0, 1);
        add_step(1, 0, 0, 0, 0, 4'b1000, 0, 2);
        add_step(1, 0, 0, 0, 0, 4'b0101, 0, 3);
        add_step(1, 0, 0, 0, 0, 4'b1010, 0, 0);
        add_step(1, 0, 0, 0, 0, 4'b1111, 0, 1);
        add_step(0, 0, 0, 0, 0, 4'b0000, 0, 0);
        add_step(0, 0, 0, 0, 0, 4'b0000, 0, 1);
        add_step(0, 0, 0, 0, 0, 4'b0000, 0, 2);
        add_step(0, 0, 0, 0, 0, 4'b0000, 0, 3);
        // Back-to-back writes to one register.
        add_step(1, 12, 1, 0, 0, 4'b0000, 12, 0);
        add_step(1, 12, 1, 1, 0, 4'b0000, 12, 0);
        add_step(0, 0, 0, 0, 0, 4'b0000, 12, 0);
        add_step(0, 0, 0, 0, 0, 4'b0000, 3, 0);
    endtask

    initial begin
        int waited;
        int target;
        lfsr      = 16'd46836;
        rst_n     = 1'b0;
        valid     = 1'b0;
        mem_rdata = '0;
        ex_result = '0;
        csrs      = '0;
        pc        = '0;
        rd        = '0;
        csr_wen   = '0;
        r_wen     = 1'b0;
        mem_ren   = 1'b0;
        jump_flag = 1'b0;
        rs1_addr  = '0;
        csr_ridx  = '0;
        build_table();
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clk);
            #1;
            {valid, rd, r_wen, mem_ren, jump_flag, csr_wen, rs1_addr, csr_ridx} = steps[i];
            next_word(mem_rdata);
            next_word(ex_result);
            next_word(csrs);
            next_word(pc);
        end

        @(posedge clk);
        #1 valid = 1'b0;
        // Two comparisons per cycle. The first entry falls in the checker's
        // warm-up cycle, and one cycle after the table takes its place.
        target = 2 * steps.size();
        waited = 0;
        while (check_count < target && waited < settle_limit) begin
            @(posedge clk);
            waited++;
        end
        if (check_count < target) begin
            $display("Timeout: the checker did not finish its comparisons in time.");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            if (error_count == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

// File: verif/wb_checker.sv
// Writeback subsystem checker.
// Keeps its own model of the registers, the CSRs and the pending write,
// and compares both read ports on every falling edge.

module wb_checker #(
    parameter logic [31:0] mtvec_reset = 32'h0000_0100
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid,
    input  logic [31:0] mem_rdata,
    input  logic [31:0] ex_result,
    input  logic [31:0] csrs,
    input  logic [31:0] pc,
    input  logic [4:0]  rd,
    input  logic [3:0]  csr_wen,
    input  logic        r_wen,
    input  logic        mem_ren,
    input  logic        jump_flag,
    input  logic [4:0]  rs1_addr,
    input  logic [1:0]  csr_ridx,
    input  logic [31:0] rs1_data,
    input  logic [31:0] csr_data,
    output int          error_count,
    output int          check_count
);

    logic [31:0] model_gpr [32];
    logic [31:0] model_csr [4];
    logic        pend_rwen;
    logic [4:0]  pend_rd;
    logic [31:0] pend_val;
    logic [3:0]  pend_cwen;
    logic [31:0] pend_cval;
    int          active_cycles;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                model_gpr[i] = '0;
            end
            for (int i = 0; i < 4; i++) begin
                model_csr[i] = '0;
            end
            model_csr[1]  = mtvec_reset;
            pend_rwen     = 1'b0;
            pend_cwen     = '0;
            active_cycles = 0;
        end else begin
            active_cycles++;
            if (pend_rwen && pend_rd != 5'd0) begin
                model_gpr[pend_rd] = pend_val;
            end
            for (int i = 0; i < 4; i++) begin
                if (pend_cwen[i]) begin
                    model_csr[i] = pend_cval;
                end
            end
            if (valid) begin
                pend_rwen = r_wen && (rd != 5'd0);
                pend_rd   = rd;
                pend_cwen = csr_wen;
                pend_cval = ex_result;
                if (jump_flag) begin
                    pend_val = pc + 32'd4;
                end else if (mem_ren) begin
                    pend_val = mem_rdata;
                end else if (csr_wen != 4'd0) begin
                    pend_val = csrs;
                end else begin
                    pend_val = ex_result;
                end
            end
        end
    end

    // Outputs are settled by the falling edge.
    always @(negedge clk) begin
        logic [31:0] exp_rs1;
        logic [31:0] exp_csr;
        if (rst_n && active_cycles >= 2) begin
            exp_rs1 = (pend_rwen && pend_rd == rs1_addr) ? pend_val : model_gpr[rs1_addr];
            exp_csr = pend_cwen[csr_ridx] ? pend_cval : model_csr[csr_ridx];
            compare_word("rs1_data", exp_rs1, rs1_data);
            compare_word("csr_data", exp_csr, csr_data);
        end
    end

endmodule

// File: verif/wb_props.sv
// Writeback subsystem assertions.
// Watches the wbu outputs and the operand_read forwarding path inside
// the top level.

module wb_props (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_rwen,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_rd_value,
    input  logic [3:0]  wb_csr_wen,
    input  logic [4:0]  rs1_addr,
    input  logic [31:0] rs1_data
);

    a_reset_clears_wen: assert property (@(posedge clk)
        !rst_n |=> (!wb_rwen && wb_csr_wen == 4'd0))
        else $error("write enables not cleared after reset");

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rwen |-> (wb_rd != 5'd0))
        else $error("register write enable high for x0");

    a_rs1_forward: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_rwen && wb_rd == rs1_addr) |-> (rs1_data == wb_rd_value))
        else $error("rs1_data does not show the forwarded value");

endmodule

bind wb_subsys_top wb_props wb_props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_rwen     (wb_rwen),
    .wb_rd       (wb_rd),
    .wb_rd_value (wb_rd_value),
    .wb_csr_wen  (wb_csr_wen),
    .rs1_addr    (rs1_addr),
    .rs1_data    (rs1_data)
);

// File: src/wb_subsys_top.sv
// Writeback subsystem top level.
// Connects the writeback unit to the register file, the CSR file and
// the forwarding read logic.

module wb_subsys_top #(
    parameter logic [wb_pkg::xlen-1:0] mtvec_reset = 32'h0000_0100
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             valid,
    input  logic [wb_pkg::xlen-1:0]          mem_rdata,
    input  logic [wb_pkg::xlen-1:0]          ex_result,
    input  logic [wb_pkg::xlen-1:0]          csrs,
    input  logic [wb_pkg::xlen-1:0]          pc,
    input  logic [wb_pkg::reg_idx_w-1:0]     rd,
    input  logic [wb_pkg::csr_count-1:0]     csr_wen,
    input  logic                             r_wen,
    input  logic                             mem_ren,
    input  logic                             jump_flag,
    input  logic [wb_pkg::reg_idx_w-1:0]     rs1_addr,
    input  logic [wb_pkg::csr_idx_w-1:0]     csr_ridx,
    output logic [wb_pkg::xlen-1:0]          rs1_data,
    output logic [wb_pkg::xlen-1:0]          csr_data
);

    logic                             wb_rwen;
    logic [wb_pkg::reg_idx_w-1:0]     wb_rd;
    logic [wb_pkg::xlen-1:0]          wb_rd_value;
    logic [wb_pkg::csr_count-1:0]     wb_csr_wen;
    logic [wb_pkg::xlen-1:0]          wb_csrd;
    logic [wb_pkg::xlen-1:0]          gpr_rdata;
    logic [wb_pkg::xlen-1:0]          csr_rdata;

    wbu wbu_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid       (valid),
        .mem_rdata   (mem_rdata),
        .ex_result   (ex_result),
        .csrs        (csrs),
        .pc          (pc),
        .rd          (rd),
        .csr_wen     (csr_wen),
        .r_wen       (r_wen),
        .mem_ren     (mem_ren),
        .jump_flag   (jump_flag),
        .wb_rwen     (wb_rwen),
        .wb_rd       (wb_rd),
        .wb_rd_value (wb_rd_value),
        .wb_csr_wen  (wb_csr_wen),
        .wb_csrd     (wb_csrd)
    );

    gpr_file gpr_file_i (
        .clk   (clk),
        .rst_n (rst_n),
        .wen   (wb_rwen),
        .waddr (wb_rd),
        .wdata (wb_rd_value),
        .raddr (rs1_addr),
        .rdata (gpr_rdata)
    );

    csr_file #(
        .mtvec_reset (mtvec_reset)
    ) csr_file_i (
        .clk   (clk),
        .rst_n (rst_n),
        .wen   (wb_csr_wen),
        .wdata (wb_csrd),
        .ridx  (csr_ridx),
        .rdata (csr_rdata)
    );

    operand_read operand_read_i (
        .rs1_addr    (rs1_addr),
        .csr_ridx    (csr_ridx),
        .gpr_rdata   (gpr_rdata),
        .csr_rdata   (csr_rdata),
        .wb_rwen     (wb_rwen),
        .wb_rd       (wb_rd),
        .wb_rd_value (wb_rd_value),
        .wb_csr_wen  (wb_csr_wen),
        .wb_csrd     (wb_csrd),
        .rs1_data    (rs1_data),
        .csr_data    (csr_data)
    );

endmodule

// File: src/operand_read.sv
// Operand read with writeback forwarding.
// Merges the register-file and CSR read ports with the write that wbu
// is retiring, so a read sees the new value before it is committed.

module operand_read (
    input  logic [wb_pkg::reg_idx_w-1:0]     rs1_addr,
    input  logic [wb_pkg::csr_idx_w-1:0]     csr_ridx,
    input  logic [wb_pkg::xlen-1:0]          gpr_rdata,
    input  logic [wb_pkg::xlen-1:0]          csr_rdata,
    input  logic                             wb_rwen,
    input  logic [wb_pkg::reg_idx_w-1:0]     wb_rd,
    input  logic [wb_pkg::xlen-1:0]          wb_rd_value,
    input  logic [wb_pkg::csr_count-1:0]     wb_csr_wen,
    input  logic [wb_pkg::xlen-1:0]          wb_csrd,
    output logic [wb_pkg::xlen-1:0]          rs1_data,
    output logic [wb_pkg::xlen-1:0]          csr_data
);

    logic rs1_fwd;
    logic csr_fwd;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // General register operand
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // wb_rwen is already low for x0, so a read of x0 never matches here.
    assign rs1_fwd = wb_rwen && (wb_rd == rs1_addr);

    always_comb begin
        if (rs1_fwd) begin
            rs1_data = wb_rd_value;
        end else begin
            rs1_data = gpr_rdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CSR operand
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The enable is one-hot by CSR index, so the read index picks its bit.
    assign csr_fwd = wb_csr_wen[csr_ridx];

    always_comb begin
        if (csr_fwd) begin
            csr_data = wb_csrd;
        end else begin
            csr_data = csr_rdata;
        end
    end

endmodule

// File: src/csr_file.sv
// Machine CSR file.
// Holds mstatus, mtvec, mepc and mcause. Each CSR is written when its
// bit of the one-hot enable is set; one indexed read port.

module csr_file #(
    parameter logic [wb_pkg::xlen-1:0] mtvec_reset = 32'h0000_0100
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [wb_pkg::csr_count-1:0]     wen,
    input  logic [wb_pkg::xlen-1:0]          wdata,
    input  logic [wb_pkg::csr_idx_w-1:0]     ridx,
    output logic [wb_pkg::xlen-1:0]          rdata
);

    logic [wb_pkg::xlen-1:0] mstatus_q;
    logic [wb_pkg::xlen-1:0] mtvec_q;
    logic [wb_pkg::xlen-1:0] mepc_q;
    logic [wb_pkg::xlen-1:0] mcause_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CSR registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Several enable bits may be set together; each selected CSR takes
    // the same value.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus_q <= '0;
            mtvec_q   <= mtvec_reset;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else begin
            if (wen[wb_pkg::csr_mstatus]) begin
                mstatus_q <= wdata;
            end
            if (wen[wb_pkg::csr_mtvec]) begin
                mtvec_q <= wdata;
            end
            if (wen[wb_pkg::csr_mepc]) begin
                mepc_q <= wdata;
            end
            if (wen[wb_pkg::csr_mcause]) begin
                mcause_q <= wdata;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        rdata = '0;
        case (ridx)
            wb_pkg::csr_mstatus: rdata = mstatus_q;
            wb_pkg::csr_mtvec:   rdata = mtvec_q;
            wb_pkg::csr_mepc:    rdata = mepc_q;
            wb_pkg::csr_mcause:  rdata = mcause_q;
            default:             rdata = '0;
        endcase
    end

endmodule

// File: src/gpr_file.sv
// General register file.
// Thirty-two registers with one synchronous write port and one
// combinational read port. Entry 0 holds zero.

module gpr_file (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             wen,
    input  logic [wb_pkg::reg_idx_w-1:0]     waddr,
    input  logic [wb_pkg::xlen-1:0]          wdata,
    input  logic [wb_pkg::reg_idx_w-1:0]     raddr,
    output logic [wb_pkg::xlen-1:0]          rdata
);

    localparam int unsigned aw        = wb_pkg::reg_idx_w;
    localparam int unsigned gpr_count = 2 ** aw;

    logic [wb_pkg::xlen-1:0] regs [gpr_count];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < gpr_count; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // The loop starts at 1, so entry 0 keeps its reset value.
            for (int i = 1; i < gpr_count; i++) begin
                if (wen && (waddr == i[aw-1:0])) begin
                    regs[i] <= wdata;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Reads see the array as it stands; a write in flight is forwarded
    // outside this block.
    assign rdata = regs[raddr];

endmodule

// File: wbu/wbu.sv
// Writeback unit.
// Registers the retiring instruction while valid is high and picks the
// value written to the destination register. The execute result is also
// passed on as the new CSR value.

module wbu (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             valid,
    input  logic [wb_pkg::xlen-1:0]          mem_rdata,
    input  logic [wb_pkg::xlen-1:0]          ex_result,
    input  logic [wb_pkg::xlen-1:0]          csrs,
    input  logic [wb_pkg::xlen-1:0]          pc,
    input  logic [wb_pkg::reg_idx_w-1:0]     rd,
    input  logic [wb_pkg::csr_count-1:0]     csr_wen,
    input  logic                             r_wen,
    input  logic                             mem_ren,
    input  logic                             jump_flag,
    output logic                             wb_rwen,
    output logic [wb_pkg::reg_idx_w-1:0]     wb_rd,
    output logic [wb_pkg::xlen-1:0]          wb_rd_value,
    output logic [wb_pkg::csr_count-1:0]     wb_csr_wen,
    output logic [wb_pkg::xlen-1:0]          wb_csrd
);

    logic                             r_wen_q;
    logic [wb_pkg::csr_count-1:0]     csr_wen_q;
    logic [wb_pkg::xlen-1:0]          mem_rdata_q;
    logic [wb_pkg::xlen-1:0]          ex_result_q;
    logic [wb_pkg::xlen-1:0]          csrs_q;
    logic [wb_pkg::xlen-1:0]          pc_q;
    logic [wb_pkg::reg_idx_w-1:0]     rd_q;
    logic                             mem_ren_q;
    logic                             jump_flag_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Writes to x0 are dropped here, so nothing downstream checks rd.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_wen_q   <= 1'b0;
            csr_wen_q <= '0;
        end else if (valid) begin
            r_wen_q   <= r_wen && (rd != '0);
            csr_wen_q <= csr_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            mem_rdata_q <= mem_rdata;
            ex_result_q <= ex_result;
            csrs_q      <= csrs;
            pc_q        <= pc;
            rd_q        <= rd;
            mem_ren_q   <= mem_ren;
            jump_flag_q <= jump_flag;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Destination value select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Jump beats load, load beats CSR read, and the ALU result is the fallback.
    always_comb begin
        if (jump_flag_q) begin
            wb_rd_value = pc_q + wb_pkg::pc_step;
        end else if (mem_ren_q) begin
            wb_rd_value = mem_rdata_q;
        end else if (|csr_wen_q) begin
            wb_rd_value = csrs_q;
        end else begin
            wb_rd_value = ex_result_q;
        end
    end

    assign wb_rwen    = r_wen_q;
    assign wb_rd      = rd_q;
    assign wb_csr_wen = csr_wen_q;
    assign wb_csrd    = ex_result_q;

endmodule

// File: common/wb_pkg.sv
// Writeback subsystem shared definitions.
// Data and index widths, the machine CSR set and its index encoding,
// and the return-address step for jumps.

package wb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int unsigned xlen      = 32;
    localparam int unsigned reg_idx_w = 5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Machine CSRs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The CSR write enable is one-hot, one bit per CSR.
    localparam int unsigned csr_count = 4;
    localparam int unsigned csr_idx_w = 2;

    // Read index of each CSR, and its bit position in the write enable.
    localparam logic [csr_idx_w-1:0] csr_mstatus = 2'd0;
    localparam logic [csr_idx_w-1:0] csr_mtvec   = 2'd1;
    localparam logic [csr_idx_w-1:0] csr_mepc    = 2'd2;
    localparam logic [csr_idx_w-1:0] csr_mcause  = 2'd3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control flow
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Offset from a jump's pc to its return address.
    localparam logic [xlen-1:0] pc_step = 32'd4;

endpackage
